/* Makefile */
# Verilator flow for the microcode load-file receiver
VERILATOR ?= verilator
TOP       ?= klxLoaderTb
RTL_TOP   ?= klxLoader
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= *** PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Exit status comes from the search for the pass message
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* design/asciiFieldDecoder.sv */
// Character phase tracking and ASCIIized field accumulation into 16-bit words
`timescale 1ns/1ns

module asciiFieldDecoder (
  input  logic             clk,
  input  logic             arstN,
  input  logic             charValid,
  input  logic [7:0]       charCode,
  output logic             typeValid,
  output klxPkg::fieldBeat field
);
  import klxPkg::*;

  // Where in the line the next character lands
  typedef enum logic [1:0] {
    phType,
    phSpace,
    phField
  } decPhase;

  decPhase phase;
  loadWord acc;
  logic    isCr;
  logic    isLf;
  logic    isDelim;

  assign isCr    = charCode == 8'd13;
  assign isLf    = charCode == 8'd10;
  assign isDelim = isLf || (charCode == ",");

  // Type character of a new line, blank line breaks are not types
  assign typeValid = charValid && (phase == phType) && !isCr && !isLf;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      phase <= phType;
      acc   <= '0;
      field <= '0;
    end else begin
      field.valid   <= 1'b0;
      field.lineEnd <= 1'b0;
      // Carriage return is dropped everywhere
      if (charValid && !isCr) begin
        case (phase)
          phType: begin
            if (!isLf) phase <= phSpace;
          end
          phSpace: begin
            // Bare type char then newline gives one empty field
            if (isLf) begin
              field.valid   <= 1'b1;
              field.word    <= '0;
              field.lineEnd <= 1'b1;
              phase         <= phType;
            end else begin
              phase <= phField;
            end
          end
          default: begin
            if (isDelim) begin
              field.valid   <= 1'b1;
              field.word    <= acc;
              field.lineEnd <= isLf;
              acc           <= '0;
              if (isLf) phase <= phType;
            end else begin
              // Low six bits per char, oldest bits fall off the top
              acc <= {acc[9:0], charCode[5:0]};
            end
          end
        endcase
      end
    end
  end

endmodule

/* design/cramWordAssembler.sv */
// CRAM word packing from six load-file words and microcode version extraction
`timescale 1ns/1ns
`include "klx_defines.svh"

module cramWordAssembler (
  input  logic                clk,
  input  logic                arstN,
  input  klxPkg::recWord      word,
  output klxPkg::cramWrite    cramWr,
  output klxPkg::ucodeVersion version
);
  import klxPkg::*;

  logic [2:0] cnt;
  cramWord    acc;
  cramWord    accNext;
  logic       take;
  logic       groupEnd;
  // Version fields held from location 136
  logic [5:0] major136;
  logic [2:0] minor136;

  assign take     = word.valid && (word.kind == cram);
  assign groupEnd = cnt == 3'(`KLX_CRAM_WORDS - 1);

  //////////////////////////////
  // Bit placement
  //////////////////////////////

  // Load-file order is 64-79, 48-63, 32-47, 16-31, 0-15, 80-85
  always_comb begin
    accNext = acc;
    case (cnt)
      3'd0:    accNext[64:79] = word.data;
      3'd1:    accNext[48:63] = word.data;
      3'd2:    accNext[32:47] = word.data;
      3'd3:    accNext[16:31] = word.data;
      3'd4:    accNext[0:15]  = word.data;
      default: accNext[80:85] = word.data[5:0];
    endcase
  end

  always_ff @(posedge clk) begin
    if (take) acc <= accNext;
  end

  //////////////////////////////
  // Write and version strobes
  //////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cnt      <= '0;
      cramWr   <= '0;
      version  <= '0;
      major136 <= '0;
      minor136 <= '0;
    end else begin
      cramWr.valid  <= 1'b0;
      version.valid <= 1'b0;
      if (take) begin
        if (groupEnd) begin
          cnt          <= '0;
          cramWr.valid <= 1'b1;
          cramWr.adr   <= cramAdr'(word.adr);
          cramWr.data  <= accNext;
          // Major and minor live in 136
          if (word.adr == `KLX_VER_ADR_HI) begin
            major136 <= {accNext[29:31], accNext[33:35]};
            minor136 <= accNext[37:39];
          end
          // Edit in 137, reported with that write
          if (word.adr == `KLX_VER_ADR_LO) begin
            version.valid <= 1'b1;
            version.major <= major136;
            version.minor <= minor136;
            version.edit  <= {accNext[29:31], accNext[33:35], accNext[37:39]};
          end
        end else begin
          cnt <= cnt + 3'd1;
        end
      end
    end
  end

  assert property (@(posedge clk) disable iff (!arstN) cnt <= 3'(`KLX_CRAM_WORDS - 1));

endmodule

/* design/dramPairAssembler.sv */
// DRAM even/odd entry building from three load-file words and paired write strobes
`timescale 1ns/1ns
`include "klx_defines.svh"

module dramPairAssembler (
  input  logic             clk,
  input  logic             arstN,
  input  klxPkg::recWord   word,
  output klxPkg::dramWrite dramWr
);
  import klxPkg::*;

  logic [1:0] cnt;
  loadWord    evenWord;
  loadWord    oddWord;
  dramEntry   oddEntry;
  // Odd write goes out on the next cycle
  logic       oddPend;
  logic       take;
  logic       groupEnd;

  assign take     = word.valid && (word.kind == dram);
  assign groupEnd = cnt == 2'(`KLX_DRAM_WORDS - 1);

  // A 13-11, B 10-8, parity 5, J08-J10 2-0
  // J01-J04 from common, J07 shared from the odd word, J05 J06 absent
  function automatic dramEntry buildEntry(loadWord w, loadWord common, logic j07);
    dramEntry e;
    e.a      = w[13:11];
    e.b      = w[10:8];
    e.parity = w[5];
    e.jump   = {common[3:0], 2'b00, j07, w[2:0]};
    return e;
  endfunction

  // Even then odd word of the group
  always_ff @(posedge clk) begin
    if (take && cnt == 2'd0) evenWord <= word.data;
    if (take && cnt == 2'd1) oddWord <= word.data;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cnt      <= '0;
      dramWr   <= '0;
      oddEntry <= '0;
      oddPend  <= 1'b0;
    end else begin
      dramWr.valid <= 1'b0;
      oddPend      <= 1'b0;
      // Odd entry follows at the even address plus one
      if (oddPend) begin
        dramWr.valid <= 1'b1;
        dramWr.adr   <= dramAdr'(dramWr.adr + 1'b1);
        dramWr.entry <= oddEntry;
      end
      if (take) begin
        if (groupEnd) begin
          // Common word closes the pair
          cnt          <= '0;
          dramWr.valid <= 1'b1;
          dramWr.adr   <= dramAdr'(word.adr);
          dramWr.entry <= buildEntry(evenWord, word.data, oddWord[3]);
          oddEntry     <= buildEntry(oddWord, word.data, oddWord[3]);
          oddPend      <= 1'b1;
        end else begin
          cnt <= cnt + 2'd1;
        end
      end
    end
  end

  // Pairs start on even locations
  assert property (@(posedge clk) disable iff (!arstN)
    (dramWr.valid && oddPend) |-> !dramWr.adr[0]);

endmodule

/* design/klxLoader.sv */
// Load-file receiver top with decoder, parser and CRAM and DRAM assemblers
`timescale 1ns/1ns

module klxLoader (
  input  logic                clk,
  input  logic                arstN,
  input  logic                charValid,
  input  logic [7:0]          charCode,
  output klxPkg::cramWrite    cramWr,
  output klxPkg::dramWrite    dramWr,
  output klxPkg::ucodeVersion version,
  output logic                lineDone,
  output logic                lineGood,
  output logic                formatError
);
  import klxPkg::*;

  logic     typeValid;
  fieldBeat field;
  recWord   word;

  asciiFieldDecoder decoder (
    .clk       (clk),
    .arstN     (arstN),
    .charValid (charValid),
    .charCode  (charCode),
    .typeValid (typeValid),
    .field     (field)
  );

  loadRecordParser parser (
    .clk         (clk),
    .arstN       (arstN),
    .typeValid   (typeValid),
    .charCode    (charCode),
    .field       (field),
    .word        (word),
    .lineDone    (lineDone),
    .lineGood    (lineGood),
    .formatError (formatError)
  );

  // Both assemblers see every record word and keep their own kind
  cramWordAssembler cramPath (
    .clk     (clk),
    .arstN   (arstN),
    .word    (word),
    .cramWr  (cramWr),
    .version (version)
  );

  dramPairAssembler dramPath (
    .clk    (clk),
    .arstN  (arstN),
    .word   (word),
    .dramWr (dramWr)
  );

endmodule

/* design/klxPkg.sv */
// Load-file word types, record kind enum and the write and version structs
`include "klx_defines.svh"

package klxPkg;

  //////////////////////////////
  // Plain vectors
  //////////////////////////////

  typedef logic [`KLX_WORD_W-1:0] loadWord;
  // Bit 0 is the most significant bit, KL10 numbering
  typedef logic [0:`KLX_CRAM_W-1] cramWord;
  typedef logic [`KLX_CRAM_ADR_W-1:0] cramAdr;
  typedef logic [`KLX_DRAM_ADR_W-1:0] dramAdr;

  // Record type from the first character of a line
  typedef enum logic [1:0] {
    none,
    zero,
    cram,
    dram
  } recKind;

  //////////////////////////////
  // Structs between the blocks
  //////////////////////////////

  // One decoded field, lineEnd marks the field closed by newline
  typedef struct packed {
    logic    valid;
    loadWord word;
    logic    lineEnd;
  } fieldBeat;

  // One data word of a record with its running address
  typedef struct packed {
    logic    valid;
    recKind  kind;
    loadWord adr;
    loadWord data;
  } recWord;

  typedef struct packed {
    logic    valid;
    cramAdr  adr;
    cramWord data;
  } cramWrite;

  // One dispatch entry, jump[1] is J01
  typedef struct packed {
    logic [2:0]  a;
    logic [2:0]  b;
    logic        parity;
    logic [1:10] jump;
  } dramEntry;

  typedef struct packed {
    logic     valid;
    dramAdr   adr;
    dramEntry entry;
  } dramWrite;

  typedef struct packed {
    logic       valid;
    logic [5:0] major;
    logic [2:0] minor;
    logic [8:0] edit;
  } ucodeVersion;

endpackage

/* design/loadRecordParser.sv */
// Record FSM with field counting, checksum check and per-kind address continuation
`timescale 1ns/1ns
`include "klx_defines.svh"

module loadRecordParser (
  input  logic             clk,
  input  logic             arstN,
  input  logic             typeValid,
  input  logic [7:0]       charCode,
  input  klxPkg::fieldBeat field,
  output klxPkg::recWord   word,
  output logic             lineDone,
  output logic             lineGood,
  output logic             formatError
);
  import klxPkg::*;

  typedef enum logic [2:0] {
    idle,
    readWc,
    readAdr,
    readData,
    readCksum,
    skip
  } recState;

  recState    state;
  recKind     kind;
  loadWord    wc;
  loadWord    sum;
  loadWord    fieldCnt;
  loadWord    dataCnt;
  loadWord    curAdr;
  // Next address after the last group of each kind
  loadWord    lastCram;
  loadWord    lastDram;
  logic [2:0] grp;

  loadWord    wcNow;
  loadWord    sumNext;
  loadWord    cntNext;
  loadWord    step;
  loadWord    base;
  logic       inLine;
  logic       countOk;
  logic       grpLast;

  assign inLine  = state inside {readWc, readAdr, readData, readCksum};
  // WC may be the very field that closes the line
  assign wcNow   = (state == readWc) ? field.word : wc;
  assign sumNext = sum + field.word;
  assign cntNext = fieldCnt + 16'd1;
  // WC, ADR, data and CKSUM
  assign countOk = cntNext == wcNow + 16'd3;
  assign step    = (kind == dram) ? 16'd2 : 16'd1;

  always_comb begin
    case (kind)
      cram:    grpLast = grp == 3'(`KLX_CRAM_WORDS - 1);
      dram:    grpLast = grp == 3'(`KLX_DRAM_WORDS - 1);
      default: grpLast = 1'b0;
    endcase
  end

  // ADR zero continues where this kind left off
  always_comb begin
    if (field.word != '0 || kind == zero)
      base = field.word;
    else if (kind == cram)
      base = lastCram;
    else
      base = lastDram;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state       <= idle;
      kind        <= none;
      wc          <= '0;
      sum         <= '0;
      fieldCnt    <= '0;
      dataCnt     <= '0;
      curAdr      <= '0;
      lastCram    <= '0;
      lastDram    <= '0;
      grp         <= '0;
      word        <= '0;
      lineDone    <= 1'b0;
      lineGood    <= 1'b0;
      formatError <= 1'b0;
    end else begin
      word.valid  <= 1'b0;
      lineDone    <= 1'b0;
      formatError <= 1'b0;

      if (field.valid && inLine) begin
        sum      <= sumNext;
        fieldCnt <= cntNext;
        if (field.lineEnd) begin
          // Negated checksum makes the whole line sum to zero
          lineDone    <= 1'b1;
          lineGood    <= countOk && (sumNext == '0);
          formatError <= !countOk;
          state       <= idle;
        end else begin
          case (state)
            readWc: begin
              wc    <= field.word;
              state <= readAdr;
            end
            readAdr: begin
              curAdr  <= base;
              grp     <= '0;
              dataCnt <= '0;
              // WC zero is an end marker
              state   <= (wc == '0) ? readCksum : readData;
            end
            readData: begin
              word.valid <= 1'b1;
              word.kind  <= kind;
              word.adr   <= curAdr;
              word.data  <= field.word;
              dataCnt    <= dataCnt + 16'd1;
              if (dataCnt == wc - 16'd1) state <= readCksum;
              // Address moves once per CRAM word or DRAM pair
              if (grpLast) begin
                grp    <= '0;
                curAdr <= curAdr + step;
                if (kind == cram) lastCram <= curAdr + step;
                if (kind == dram) lastDram <= curAdr + step;
              end else begin
                grp <= grp + 3'd1;
              end
            end
            default: begin
              // Surplus field, caught by the count at line end
            end
          endcase
        end
      end else if (field.valid && state == skip && field.lineEnd) begin
        state <= idle;
      end

      // A new line restarts the FSM whatever is still pending
      if (typeValid) begin
        sum      <= '0;
        fieldCnt <= '0;
        state    <= readWc;
        case (charCode)
          "Z": kind <= zero;
          "C": kind <= cram;
          "D": kind <= dram;
          ";": begin
            kind  <= none;
            state <= skip;
          end
          default: begin
            kind        <= none;
            state       <= skip;
            formatError <= 1'b1;
          end
        endcase
      end
    end
  end

  // Comment and rejected lines never reach the assemblers
  assert property (@(posedge clk) disable iff (!arstN) (state == skip) |-> !word.valid);

endmodule

/* flist.f */
+incdir+include
design/klxPkg.sv
design/asciiFieldDecoder.sv
design/loadRecordParser.sv
design/cramWordAssembler.sv
design/dramPairAssembler.sv
design/klxLoader.sv
tb/klxLoaderTb.sv

/* include/klx_defines.svh */
// Width, record-size and version-location macros for the microcode load-file receiver
`ifndef KLX_DEFINES_SVH
`define KLX_DEFINES_SVH

// Load-file word, one ASCIIized field
`define KLX_WORD_W      16

// CRAM word is 80 bits plus the six-bit CALL/DISP field
`define KLX_CRAM_W      86
`define KLX_CRAM_ADR_W  11
`define KLX_DRAM_ADR_W  9

// Load-file words per CRAM location and per DRAM even/odd pair
`define KLX_CRAM_WORDS  6
`define KLX_DRAM_WORDS  3

// CRAM locations that hold the microcode version
`define KLX_VER_ADR_HI  16'o136
`define KLX_VER_ADR_LO  16'o137

`endif

/* tb/klxLoaderTb.sv */
// Directed testbench for klxLoader with line encoding, write capture and value checks
`timescale 1ns/1ns
`include "klx_defines.svh"

module klxLoaderTb;
  import klxPkg::*;

  logic        clk;
  logic        arstN;
  logic        charValid;
  logic [7:0]  charCode;
  cramWrite    cramWr;
  dramWrite    dramWr;
  ucodeVersion version;
  logic        lineDone;
  logic        lineGood;
  logic        formatError;

  int          errors;
  int          checks;
  int          fmtCount;
  logic [31:0] rngState;
  // WC, ADR and data of the next line, checksum is added on sending
  loadWord     lineWords[$];
  cramWrite    cramQ[$];
  dramWrite    dramQ[$];
  ucodeVersion verQ[$];
  bit          verWithWrite[$];
  bit          goodQ[$];

  klxLoader UUT (
    .clk         (clk),
    .arstN       (arstN),
    .charValid   (charValid),
    .charCode    (charCode),
    .cramWr      (cramWr),
    .dramWr      (dramWr),
    .version     (version),
    .lineDone    (lineDone),
    .lineGood    (lineGood),
    .formatError (formatError)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // Capture of DUT strobes
  //////////////////////////////

  // Falling edge, outputs settled since the rising edge
  always @(negedge clk) begin
    if (cramWr.valid) cramQ.push_back(cramWr);
    if (dramWr.valid) dramQ.push_back(dramWr);
    if (version.valid) begin
      verQ.push_back(version);
      verWithWrite.push_back(cramWr.valid && cramWr.adr == cramAdr'(`KLX_VER_ADR_LO));
    end
    if (lineDone) goodQ.push_back(lineGood);
    if (formatError) fmtCount++;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // xorshift32, low half used as a data word
  function automatic loadWord nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState[15:0];
  endfunction

  // C line order is 64-79, 48-63, 32-47, 16-31, 0-15, then 80-85
  function automatic cramWord expectedCram(int first);
    cramWord e;
    e = '0;
    e[64:79] = lineWords[first];
    e[48:63] = lineWords[first + 1];
    e[32:47] = lineWords[first + 2];
    e[16:31] = lineWords[first + 3];
    e[0:15]  = lineWords[first + 4];
    e[80:85] = lineWords[first + 5][5:0];
    return e;
  endfunction

  function automatic dramEntry expectedDram(loadWord w, loadWord common, loadWord odd);
    dramEntry e;
    e.a         = w[13:11];
    e.b         = w[10:8];
    e.parity    = w[5];
    e.jump[1:4] = common[3:0];
    e.jump[5]   = 1'b0;
    e.jump[6]   = 1'b0;
    // J07 always from the odd word
    e.jump[7]    = odd[3];
    e.jump[8:10] = w[2:0];
    return e;
  endfunction

  task automatic checkValue(input string label, input logic [127:0] expected,
                            input logic [127:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("MISMATCH %s expected %0h actual %0h", label, expected, actual);
    end
  endtask

  task automatic reportTest(input string name, input int errBefore);
    $display("test %s %0d error(s)", name, errors - errBefore);
  endtask

  task automatic clearCaptures();
    cramQ.delete();
    dramQ.delete();
    verQ.delete();
    verWithWrite.delete();
    goodQ.delete();
    fmtCount = 0;
  endtask

  // One character, then a free cycle
  task automatic sendChar(input logic [7:0] c);
    @(posedge clk);
    #1;
    charValid = 1'b1;
    charCode  = c;
    @(posedge clk);
    #1;
    charValid = 1'b0;
  endtask

  task automatic sendText(input string s);
    int i;
    for (i = 0; i < s.len(); i++) sendChar(s[i]);
  endtask

  // Three chars per word, 0x40 keeps every char clear of delimiters
  task automatic sendWord(input loadWord w);
    sendChar({4'b0100, w[15:12]});
    sendChar({2'b01, w[11:6]});
    sendChar({2'b01, w[5:0]});
  endtask

  task automatic sendLine(input logic [7:0] kind, input bit corrupt);
    loadWord sum;
    loadWord cksum;
    int      i;
    sum = '0;
    for (i = 0; i < lineWords.size(); i++) sum = sum + lineWords[i];
    // Negated so that the full line sums to zero
    cksum = -sum;
    if (corrupt) cksum = cksum ^ 16'd1;
    sendChar(kind);
    sendChar(" ");
    for (i = 0; i < lineWords.size(); i++) begin
      sendWord(lineWords[i]);
      sendChar(",");
    end
    sendWord(cksum);
    sendChar(8'd13);
    sendChar(8'd10);
  endtask

  task automatic waitLineDone(input string name);
    int n;
    for (n = 0; n < 100 && goodQ.size() == 0; n++) @(posedge clk);
    if (goodQ.size() == 0) begin
      errors++;
      $display("%s: lineDone did not arrive within 100 cycles", name);
    end
  endtask

  task automatic waitFormatError(input string name);
    int n;
    for (n = 0; n < 100 && fmtCount == 0; n++) @(posedge clk);
    if (fmtCount == 0) begin
      errors++;
      $display("%s: formatError did not arrive within 100 cycles", name);
    end
  endtask

  task automatic idleCycles(input int count);
    int n;
    for (n = 0; n < count; n++) @(posedge clk);
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic loadTwoCramWords();
    int      errBefore;
    int      i;
    cramWord exp;
    errBefore = errors;
    clearCaptures();
    lineWords.delete();
    lineWords.push_back(16'd12);
    lineWords.push_back(16'o200);
    for (i = 0; i < 12; i++) lineWords.push_back(nextRand());
    sendLine("C", 1'b0);
    waitLineDone("cramLine");
    checkValue("cramLine writes", 128'(2), 128'(cramQ.size()));
    for (i = 0; i < 2 && i < cramQ.size(); i++) begin
      exp = expectedCram(2 + 6 * i);
      checkValue($sformatf("cramLine adr %0d", i), 128'(16'o200 + i), 128'(cramQ[i].adr));
      checkValue($sformatf("cramLine data %0d", i), 128'(exp), 128'(cramQ[i].data));
    end
    if (goodQ.size() > 0) checkValue("cramLine lineGood", 128'(1), 128'(goodQ[0]));
    checkValue("cramLine formatError", 128'(0), 128'(fmtCount));
    reportTest("cramLine", errBefore);
  endtask

  task automatic loadDramPairs();
    int      errBefore;
    int      p;
    loadWord even;
    loadWord odd;
    loadWord common;
    errBefore = errors;
    clearCaptures();
    lineWords.delete();
    lineWords.push_back(16'd6);
    lineWords.push_back(16'o40);
    for (p = 0; p < 2; p++) begin
      even   = nextRand();
      odd    = nextRand();
      common = nextRand();
      // J07 set in one pair and clear in the other
      odd[3] = (p == 0);
      lineWords.push_back(even);
      lineWords.push_back(odd);
      lineWords.push_back(common);
    end
    sendLine("D", 1'b0);
    waitLineDone("dramLine");
    checkValue("dramLine writes", 128'(4), 128'(dramQ.size()));
    for (p = 0; p < 2 && dramQ.size() == 4; p++) begin
      even   = lineWords[2 + 3 * p];
      odd    = lineWords[3 + 3 * p];
      common = lineWords[4 + 3 * p];
      checkValue($sformatf("dramLine even adr %0d", p), 128'(16'o40 + 2 * p),
                 128'(dramQ[2 * p].adr));
      checkValue($sformatf("dramLine even entry %0d", p),
                 128'(expectedDram(even, common, odd)), 128'(dramQ[2 * p].entry));
      checkValue($sformatf("dramLine odd adr %0d", p), 128'(16'o41 + 2 * p),
                 128'(dramQ[2 * p + 1].adr));
      checkValue($sformatf("dramLine odd entry %0d", p),
                 128'(expectedDram(odd, common, odd)), 128'(dramQ[2 * p + 1].entry));
    end
    if (goodQ.size() > 0) checkValue("dramLine lineGood", 128'(1), 128'(goodQ[0]));
    reportTest("dramLine", errBefore);
  endtask

  // Relies on the C line at 200 having written 200 and 201
  task automatic continueCramAddress();
    int errBefore;
    int i;
    errBefore = errors;
    clearCaptures();
    lineWords.delete();
    lineWords.push_back(16'd6);
    lineWords.push_back(16'd0);
    for (i = 0; i < 6; i++) lineWords.push_back(nextRand());
    sendLine("C", 1'b0);
    waitLineDone("continuation");
    checkValue("continuation writes", 128'(1), 128'(cramQ.size()));
    if (cramQ.size() > 0) begin
      checkValue("continuation adr", 128'(16'o202), 128'(cramQ[0].adr));
      checkValue("continuation data", 128'(expectedCram(2)), 128'(cramQ[0].data));
    end
    // End marker, WC zero
    clearCaptures();
    lineWords.delete();
    lineWords.push_back(16'd0);
    lineWords.push_back(16'd0);
    sendLine("C", 1'b0);
    waitLineDone("continuation");
    checkValue("continuation end writes", 128'(0), 128'(cramQ.size() + dramQ.size()));
    if (goodQ.size() > 0) checkValue("continuation end lineGood", 128'(1), 128'(goodQ[0]));
    reportTest("continuation", errBefore);
  endtask

  task automatic rejectBadLines();
    int errBefore;
    int i;
    errBefore = errors;
    // Z line with its checksum off by one
    clearCaptures();
    lineWords.delete();
    lineWords.push_back(16'd6);
    lineWords.push_back(16'o300);
    // Six words would close whole CRAM and DRAM groups if Z words leaked
    for (i = 0; i < 6; i++) lineWords.push_back(nextRand());
    sendLine("Z", 1'b1);
    waitLineDone("badLines");
    if (goodQ.size() > 0) checkValue("badLines cksum lineGood", 128'(0), 128'(goodQ[0]));
    checkValue("badLines cksum formatError", 128'(0), 128'(fmtCount));
    checkValue("badLines cksum writes", 128'(0), 128'(cramQ.size() + dramQ.size()));
    // Unknown type character
    clearCaptures();
    sendLine("X", 1'b0);
    waitFormatError("badLines");
    idleCycles(10);
    checkValue("badLines type formatError", 128'(1), 128'(fmtCount));
    checkValue("badLines type lineDone", 128'(0), 128'(goodQ.size()));
    // Comment line leaves every output quiet
    clearCaptures();
    sendText("; comment, text");
    sendChar(8'd13);
    sendChar(8'd10);
    idleCycles(10);
    checkValue("badLines comment strobes", 128'(0),
               128'(cramQ.size() + dramQ.size() + verQ.size() + goodQ.size() + fmtCount));
    reportTest("badLines", errBefore);
  endtask

  task automatic extractVersion();
    int          errBefore;
    int          i;
    cramWord     loc136;
    cramWord     loc137;
    ucodeVersion exp;
    errBefore = errors;
    clearCaptures();
    lineWords.delete();
    lineWords.push_back(16'd12);
    lineWords.push_back(`KLX_VER_ADR_HI);
    for (i = 0; i < 12; i++) lineWords.push_back(nextRand());
    sendLine("C", 1'b0);
    waitLineDone("version");
    loc136    = expectedCram(2);
    loc137    = expectedCram(8);
    exp       = '0;
    exp.valid = 1'b1;
    exp.major = {loc136[29:31], loc136[33:35]};
    exp.minor = loc136[37:39];
    exp.edit  = {loc137[29:31], loc137[33:35], loc137[37:39]};
    checkValue("version writes", 128'(2), 128'(cramQ.size()));
    checkValue("version strobes", 128'(1), 128'(verQ.size()));
    if (verQ.size() > 0) begin
      checkValue("version major", 128'(exp.major), 128'(verQ[0].major));
      checkValue("version minor", 128'(exp.minor), 128'(verQ[0].minor));
      checkValue("version edit", 128'(exp.edit), 128'(verQ[0].edit));
      // Same cycle as the write to 137
      checkValue("version with write", 128'(1), 128'(verWithWrite[0]));
    end
    reportTest("version", errBefore);
  endtask

  //////////////////////////////
  // Sequence
  //////////////////////////////

  initial begin
    int errBefore;
    errors    = 0;
    checks    = 0;
    fmtCount  = 0;
    rngState  = 32'd36;
    arstN     = 1'b0;
    charValid = 1'b0;
    charCode  = 8'd0;
    repeat (8) @(posedge clk);
    #1;
    arstN = 1'b1;
    @(negedge clk);
    errBefore = errors;
    checkValue("reset strobes", 128'(0),
               128'({cramWr.valid, dramWr.valid, version.valid, lineDone, formatError}));
    reportTest("reset", errBefore);
    loadTwoCramWords();
    loadDramPairs();
    continueCramAddress();
    rejectBadLines();
    extractVersion();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
